/* verilog/deco_pkg.sv */
// decoder package with widths, register and segment codes, microcode entries and opcode views
package deco_pkg;

        localparam int SEQ_ADDR_W  = 8;
        localparam int REG_W       = 4;
        localparam int QUEUE_DEPTH = 4;         // also the upstream credit count
        localparam int OUT_CREDITS = 2;
        localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
        localparam int CRED_W      = $clog2(OUT_CREDITS + 1);
        localparam int ENTRY_W     = SEQ_ADDR_W + 5 + 4 * REG_W + 2;

        // register numbers, bit 3 reserved
        localparam logic [REG_W-1:0] REG_AX   = 4'd0;
        localparam logic [REG_W-1:0] REG_BX   = 4'd3;
        localparam logic [REG_W-1:0] REG_BP   = 4'd5;
        localparam logic [REG_W-1:0] REG_SI   = 4'd6;
        localparam logic [REG_W-1:0] REG_DI   = 4'd7;
        localparam logic [REG_W-1:0] REG_NONE = 4'b1100;

        localparam logic [1:0] SEG_ES = 2'd0;
        localparam logic [1:0] SEG_CS = 2'd1;
        localparam logic [1:0] SEG_SS = 2'd2;
        localparam logic [1:0] SEG_DS = 2'd3;

        localparam logic [2:0] KIND_RR = 3'd0;
        localparam logic [2:0] KIND_RM = 3'd1;
        localparam logic [2:0] KIND_MR = 3'd2;
        localparam logic [2:0] KIND_IR = 3'd3;
        localparam logic [2:0] KIND_IM = 3'd4;

        localparam logic [SEQ_ADDR_W-1:0] SEQ_MOVRR = 8'd128;   // +w
        localparam logic [SEQ_ADDR_W-1:0] SEQ_MOVRM = 8'd130;   // +w
        localparam logic [SEQ_ADDR_W-1:0] SEQ_MOVMR = 8'd132;   // +w
        localparam logic [SEQ_ADDR_W-1:0] SEQ_INCRW = 8'd134;
        localparam logic [SEQ_ADDR_W-1:0] SEQ_DECRW = 8'd135;
        localparam logic [SEQ_ADDR_W-1:0] SEQ_PUSHR = 8'd136;
        localparam logic [SEQ_ADDR_W-1:0] SEQ_POPR  = 8'd137;
        localparam logic [SEQ_ADDR_W-1:0] SEQ_JCC   = 8'd138;
        localparam logic [SEQ_ADDR_W-1:0] SEQ_HLT   = 8'd139;

        // one opcode byte, seen as alu fields or as short register form
        typedef union packed {
                struct packed {
                        logic [1:0] pfx;
                        logic [2:0] alu_op;
                        logic       form;       // 1 for accumulator immediate
                        logic       d;
                        logic       w;
                } alu;
                struct packed {
                        logic [4:0] grp;
                        logic [2:0] r;
                } rg;
        } opcode_u;

        // alu entry is op*16 + kind*2 + w
        function automatic logic [SEQ_ADDR_W-1:0] alu_entry(input logic [2:0] alu_op,
                                                            input logic [2:0] kind,
                                                            input logic       w);
                return {1'b0, alu_op, kind, w};
        endfunction

endpackage

/* verilog/memory_regs.sv */
// effective-address table, maps mod/rm and segment override to base, index and segment
`timescale 1ns/1ps

module memory_regs
        import deco_pkg::*;
(
        input  logic [1:0]       mod,
        input  logic [2:0]       rm,
        input  logic [2:0]       sovr_pr,
        output logic [REG_W-1:0] base,
        output logic [REG_W-1:0] index,
        output logic [1:0]       seg,
        output logic             direct
);

        logic [1:0] def_seg;

        assign direct = (mod == 2'b00) && (rm == 3'b110);
        assign seg    = sovr_pr[2] ? sovr_pr[1:0] : def_seg;   // override wins

        always_comb
        begin
                case (rm)
                3'b000:  {base, index, def_seg} = {REG_BX, REG_SI, SEG_DS};
                3'b001:  {base, index, def_seg} = {REG_BX, REG_DI, SEG_DS};
                3'b010:  {base, index, def_seg} = {REG_BP, REG_SI, SEG_SS};
                3'b011:  {base, index, def_seg} = {REG_BP, REG_DI, SEG_SS};
                3'b100:  {base, index, def_seg} = {REG_SI, REG_NONE, SEG_DS};
                3'b101:  {base, index, def_seg} = {REG_DI, REG_NONE, SEG_DS};
                3'b110:  {base, index, def_seg} = {REG_BP, REG_NONE, SEG_SS};
                default: {base, index, def_seg} = {REG_BX, REG_NONE, SEG_DS};
                endcase
                if (direct)     // plain disp16 address
                begin
                        {base, index, def_seg} = {REG_NONE, REG_NONE, SEG_DS};
                end
        end

endmodule

/* verilog/modrm_stage.sv */
// first decode stage, captures the input bytes and registers the modrm-derived fields
`timescale 1ns/1ps

module modrm_stage
        import deco_pkg::*;
(
        input  logic             clk,
        input  logic             rst_n,
        input  logic             in_valid,
        input  logic [7:0]       op,
        input  logic [7:0]       modrm,
        input  logic [2:0]       sovr_pr,
        output logic             s1_valid,
        output opcode_u          s1_op,
        output logic [1:0]       s1_mod,
        output logic [2:0]       s1_reg,
        output logic [2:0]       s1_rm,
        output logic [REG_W-1:0] s1_base,
        output logic [REG_W-1:0] s1_index,
        output logic [1:0]       s1_seg,
        output logic             s1_disp,
        output logic             s1_disp_wide
);

        logic [REG_W-1:0] ea_base;
        logic [REG_W-1:0] ea_index;
        logic [1:0]       ea_seg;
        logic             ea_direct;

        memory_regs u_memory_regs (
                .mod     (modrm[7:6]),
                .rm      (modrm[2:0]),
                .sovr_pr (sovr_pr),
                .base    (ea_base),
                .index   (ea_index),
                .seg     (ea_seg),
                .direct  (ea_direct)
        );

        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                        s1_valid <= 1'b0;
                else
                        s1_valid <= in_valid;
        end

        always_ff @(posedge clk)
        begin
                if (in_valid)
                begin
                        s1_op        <= op;
                        s1_mod       <= modrm[7:6];
                        s1_reg       <= modrm[5:3];
                        s1_rm        <= modrm[2:0];
                        s1_base      <= ea_base;
                        s1_index     <= ea_index;
                        s1_seg       <= ea_seg;
                        s1_disp      <= ea_direct | (modrm[7:6] == 2'b01) | (modrm[7:6] == 2'b10);
                        s1_disp_wide <= ea_direct | (modrm[7:6] == 2'b10);   // disp16
                end
        end

endmodule

/* verilog/opcode_table.sv */
// second decode stage, registered opcode lookup to microcode entry, immediates and operands
`timescale 1ns/1ps

module opcode_table
        import deco_pkg::*;
(
        input  logic                  clk,
        input  logic                  rst_n,
        input  logic                  s1_valid,
        input  opcode_u               s1_op,
        input  logic [1:0]            s1_mod,
        input  logic [2:0]            s1_reg,
        input  logic [2:0]            s1_rm,
        input  logic [REG_W-1:0]      s1_base,
        input  logic [REG_W-1:0]      s1_index,
        input  logic [1:0]            s1_seg,
        input  logic                  s1_disp,
        input  logic                  s1_disp_wide,
        output logic                  s2_valid,
        output logic [SEQ_ADDR_W-1:0] s2_seq_addr,
        output logic                  s2_need_modrm,
        output logic                  s2_need_off,
        output logic                  s2_off_size,
        output logic                  s2_need_imm,
        output logic                  s2_imm_size,
        output logic [REG_W-1:0]      s2_src,
        output logic [REG_W-1:0]      s2_dst,
        output logic [REG_W-1:0]      s2_base,
        output logic [REG_W-1:0]      s2_index,
        output logic [1:0]            s2_seg
);

        logic [SEQ_ADDR_W-1:0] seq_addr;
        logic                  need_modrm;
        logic                  need_imm;
        logic                  imm_size;
        logic [REG_W-1:0]      src;
        logic [REG_W-1:0]      dst;
        logic                  reg_form;
        logic [REG_W-1:0]      src_m;
        logic [REG_W-1:0]      dst_m;

        assign reg_form = (s1_mod == 2'b11);
        assign dst_m    = s1_op.alu.d ? {1'b0, s1_reg} : {1'b0, s1_rm};
        assign src_m    = s1_op.alu.d ? {1'b0, s1_rm} : {1'b0, s1_reg};

        always_comb
        begin
                seq_addr   = SEQ_HLT;   // anything unkept halts
                need_modrm = 1'b0;
                need_imm   = 1'b0;
                imm_size   = 1'b0;
                src        = REG_AX;
                dst        = REG_AX;
                casez (s1_op)
                8'b00???0??: // alu r/m forms
                begin
                        seq_addr   = alu_entry(s1_op.alu.alu_op,
                                               reg_form ? KIND_RR :
                                               (s1_op.alu.d ? KIND_MR : KIND_RM),
                                               s1_op.alu.w);
                        need_modrm = 1'b1;
                        src        = src_m;
                        dst        = dst_m;
                end
                8'b00???10?: // alu on accumulator
                begin
                        seq_addr = alu_entry(s1_op.alu.alu_op, KIND_IR, s1_op.alu.w);
                        need_imm = 1'b1;
                        imm_size = s1_op.alu.w;
                end
                8'b100000??: // group 1, op from modrm reg
                begin
                        seq_addr   = alu_entry(s1_reg, reg_form ? KIND_IR : KIND_IM,
                                               s1_op.alu.w);
                        need_modrm = 1'b1;
                        need_imm   = 1'b1;
                        imm_size   = s1_op.alu.w & ~s1_op.alu.d;       // only 81 has imm16
                        dst        = {1'b0, s1_rm};
                end
                8'b100010??: // mov
                begin
                        need_modrm = 1'b1;
                        if (reg_form)
                        begin
                                seq_addr = SEQ_MOVRR + SEQ_ADDR_W'(s1_op.alu.w);
                                src      = src_m;
                                dst      = dst_m;
                        end
                        else if (s1_op.alu.d)
                        begin
                                seq_addr = SEQ_MOVMR + SEQ_ADDR_W'(s1_op.alu.w);
                                dst      = {1'b0, s1_reg};
                        end
                        else
                        begin
                                seq_addr = SEQ_MOVRM + SEQ_ADDR_W'(s1_op.alu.w);
                                src      = {1'b0, s1_reg};
                        end
                end
                8'b01000???: {seq_addr, src} = {SEQ_INCRW, 1'b0, s1_op.rg.r};
                8'b01001???: {seq_addr, src} = {SEQ_DECRW, 1'b0, s1_op.rg.r};
                8'b01010???: {seq_addr, src} = {SEQ_PUSHR, 1'b0, s1_op.rg.r};
                8'b01011???: {seq_addr, dst} = {SEQ_POPR, 1'b0, s1_op.rg.r};
                8'b0111????: // jcc, condition in src
                begin
                        seq_addr = SEQ_JCC;
                        need_imm = 1'b1;
                        src      = {s1_op.rg.grp[0], s1_op.rg.r};
                end
                default: ;
                endcase
        end

        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                        s2_valid <= 1'b0;
                else
                        s2_valid <= s1_valid;
        end

        always_ff @(posedge clk)
        begin
                if (s1_valid)
                begin
                        s2_seq_addr   <= seq_addr;
                        s2_need_modrm <= need_modrm;
                        s2_need_off   <= need_modrm & s1_disp;
                        s2_off_size   <= need_modrm & s1_disp_wide;
                        s2_need_imm   <= need_imm;
                        s2_imm_size   <= imm_size;
                        s2_src        <= src;
                        s2_dst        <= dst;
                        s2_base       <= s1_base;
                        s2_index      <= s1_index;
                        s2_seg        <= s1_seg;
                end
        end

endmodule

/* verilog/deco_queue.sv */
// output queue with downstream credit counter and upstream credit return
`timescale 1ns/1ps

module deco_queue
        import deco_pkg::*;
(
        input  logic                  clk,
        input  logic                  rst_n,
        input  logic                  out_credit,
        input  logic                  s2_valid,
        input  logic [SEQ_ADDR_W-1:0] s2_seq_addr,
        input  logic                  s2_need_modrm,
        input  logic                  s2_need_off,
        input  logic                  s2_off_size,
        input  logic                  s2_need_imm,
        input  logic                  s2_imm_size,
        input  logic [REG_W-1:0]      s2_src,
        input  logic [REG_W-1:0]      s2_dst,
        input  logic [REG_W-1:0]      s2_base,
        input  logic [REG_W-1:0]      s2_index,
        input  logic [1:0]            s2_seg,
        output logic                  in_credit,
        output logic                  out_valid,
        output logic [SEQ_ADDR_W-1:0] seq_addr,
        output logic                  need_modrm,
        output logic                  need_off,
        output logic                  off_size,
        output logic                  need_imm,
        output logic                  imm_size,
        output logic [REG_W-1:0]      src,
        output logic [REG_W-1:0]      dst,
        output logic [REG_W-1:0]      base,
        output logic [REG_W-1:0]      index,
        output logic [1:0]            seg
);

        logic [ENTRY_W-1:0] mem [QUEUE_DEPTH];
        logic [QPTR_W-1:0]  wr_ptr;
        logic [QPTR_W-1:0]  rd_ptr;
        logic [QPTR_W:0]    count;
        logic [CRED_W-1:0]  credits;

        // upstream credits bound the fill, so no full check
        assign out_valid = (count != '0) && (credits != '0);
        assign in_credit = out_valid;
        assign {seq_addr, need_modrm, need_off, off_size, need_imm, imm_size,
                src, dst, base, index, seg} = mem[rd_ptr];

        always_ff @(posedge clk)
        begin
                if (s2_valid)
                        mem[wr_ptr] <= {s2_seq_addr, s2_need_modrm, s2_need_off, s2_off_size,
                                        s2_need_imm, s2_imm_size, s2_src, s2_dst,
                                        s2_base, s2_index, s2_seg};
        end

        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        wr_ptr  <= '0;
                        rd_ptr  <= '0;
                        count   <= '0;
                        credits <= CRED_W'(OUT_CREDITS);
                end
                else
                begin
                        wr_ptr  <= wr_ptr + QPTR_W'(s2_valid);
                        rd_ptr  <= rd_ptr + QPTR_W'(out_valid);
                        count   <= count + (QPTR_W + 1)'(s2_valid) - (QPTR_W + 1)'(out_valid);
                        credits <= credits - CRED_W'(out_valid) + CRED_W'(out_credit);
                end
        end

endmodule

/* verilog/opcode_deco.sv */
// pipelined opcode decoder top, modrm stage then opcode table then output queue
`timescale 1ns/1ps

module opcode_deco
        import deco_pkg::*;
(
        input  logic                  clk,
        input  logic                  rst_n,
        input  logic                  in_valid,
        input  logic [7:0]            op,
        input  logic [7:0]            modrm,
        input  logic [2:0]            sovr_pr,
        input  logic                  out_credit,
        output logic                  in_credit,
        output logic                  out_valid,
        output logic [SEQ_ADDR_W-1:0] seq_addr,
        output logic                  need_modrm,
        output logic                  need_off,
        output logic                  off_size,
        output logic                  need_imm,
        output logic                  imm_size,
        output logic [REG_W-1:0]      src,
        output logic [REG_W-1:0]      dst,
        output logic [REG_W-1:0]      base,
        output logic [REG_W-1:0]      index,
        output logic [1:0]            seg
);

        logic             s1_valid;
        opcode_u          s1_op;
        logic [1:0]       s1_mod;
        logic [2:0]       s1_reg;
        logic [2:0]       s1_rm;
        logic [REG_W-1:0] s1_base;
        logic [REG_W-1:0] s1_index;
        logic [1:0]       s1_seg;
        logic             s1_disp;
        logic             s1_disp_wide;

        logic                  s2_valid;
        logic [SEQ_ADDR_W-1:0] s2_seq_addr;
        logic                  s2_need_modrm;
        logic                  s2_need_off;
        logic                  s2_off_size;
        logic                  s2_need_imm;
        logic                  s2_imm_size;
        logic [REG_W-1:0]      s2_src;
        logic [REG_W-1:0]      s2_dst;
        logic [REG_W-1:0]      s2_base;
        logic [REG_W-1:0]      s2_index;
        logic [1:0]            s2_seg;

        modrm_stage u_modrm_stage (.*);

        opcode_table u_opcode_table (.*);

        deco_queue u_deco_queue (.*);

endmodule

/* verif/opcode_deco_tb.sv */
// opcode decoder testbench with credit-driven stimulus, reference model and field checks
`timescale 1ns/1ps

module opcode_deco_tb
        import deco_pkg::*;
;

        localparam int RANDOM_ITEMS   = 400;
        localparam int TOTAL_ITEMS    = 2 * 256 + 512 + QUEUE_DEPTH + OUT_CREDITS + RANDOM_ITEMS;
        localparam int TIMEOUT_CYCLES = 14 * TOTAL_ITEMS;      // worst case about 14 cycles/item

        typedef struct packed {
                logic [SEQ_ADDR_W-1:0] seq_addr;
                logic                  need_modrm;
                logic                  need_off;
                logic                  off_size;
                logic                  need_imm;
                logic                  imm_size;
                logic [REG_W-1:0]      src;
                logic [REG_W-1:0]      dst;
                logic [REG_W-1:0]      base;
                logic [REG_W-1:0]      index;
                logic [1:0]            seg;
        } fields_t;

        logic clk = 1'b0;
        logic rst_n;
        logic in_valid;
        logic [7:0] op;
        logic [7:0] modrm;
        logic [2:0] sovr_pr;
        logic out_credit = 1'b0;
        logic in_credit;
        logic out_valid;
        logic [SEQ_ADDR_W-1:0] seq_addr;
        logic need_modrm;
        logic need_off;
        logic off_size;
        logic need_imm;
        logic imm_size;
        logic [REG_W-1:0] src;
        logic [REG_W-1:0] dst;
        logic [REG_W-1:0] base;
        logic [REG_W-1:0] index;
        logic [1:0] seg;

        fields_t exp_q[$];
        string   name_q[$];
        fields_t exp_f;
        string   exp_name;
        int      sent_cnt = 0;
        int      ret_cnt = 0;              // in_credit pulses seen
        int      owed = 0;                 // downstream credits not yet returned
        int      cycle_cnt = 0;
        int      credit_mode = 1;          // 0 none, 1 every cycle, 2 random stretches
        int      credit_pct = 100;
        logic [4:0] stretch_cnt = '0;
        logic    quiet_check;

        opcode_deco UUT (.*);

        initial
        begin
                forever #2 clk = ~clk;
        end

        task automatic stop_run(input string why);
                $display("%s", why);
                $display("tests failed");
                $fatal(1, "run stopped at first error");
        endtask

        task automatic next_cycle();
                @(posedge clk);
                #1;
        endtask

        task automatic check_field(input string test, input string field, input int exp_v,
                                   input int act_v);
                assert (exp_v == act_v)
                else stop_run($sformatf("[FAIL] %s %s expected 0x%0h actual 0x%0h",
                                        test, field, exp_v, act_v));
        endtask

        // expected fields straight from the decode rules
        function automatic fields_t expect_fields(input logic [7:0] o, input logic [7:0] m,
                                                  input logic [2:0] s);
                fields_t    f;
                logic [1:0] md;
                logic [2:0] rg;
                logic [2:0] rm;
                logic [2:0] kind;
                logic       direct;
                md = m[7:6];
                rg = m[5:3];
                rm = m[2:0];
                direct = (md == 2'd0) && (rm == 3'd6);
                f = '0;
                f.seq_addr = SEQ_HLT;
                case (rm)
                3'd0: {f.base, f.index, f.seg} = {REG_BX, REG_SI, SEG_DS};
                3'd1: {f.base, f.index, f.seg} = {REG_BX, REG_DI, SEG_DS};
                3'd2: {f.base, f.index, f.seg} = {REG_BP, REG_SI, SEG_SS};
                3'd3: {f.base, f.index, f.seg} = {REG_BP, REG_DI, SEG_SS};
                3'd4: {f.base, f.index, f.seg} = {REG_SI, REG_NONE, SEG_DS};
                3'd5: {f.base, f.index, f.seg} = {REG_DI, REG_NONE, SEG_DS};
                3'd6: {f.base, f.index, f.seg} = {REG_BP, REG_NONE, SEG_SS};
                default: {f.base, f.index, f.seg} = {REG_BX, REG_NONE, SEG_DS};
                endcase
                if (direct)
                        {f.base, f.index, f.seg} = {REG_NONE, REG_NONE, SEG_DS};
                if (s[2])
                        f.seg = s[1:0];
                if (o < 8'h40 && o[2:0] < 3'd4)
                begin
                        kind = (md == 2'd3) ? KIND_RR : (o[1] ? KIND_MR : KIND_RM);
                        f.seq_addr = SEQ_ADDR_W'(16 * int'(o[5:3]) + 2 * int'(kind) + int'(o[0]));
                        f.need_modrm = 1'b1;
                        f.dst = o[1] ? {1'b0, rg} : {1'b0, rm};
                        f.src = o[1] ? {1'b0, rm} : {1'b0, rg};
                end
                else if (o < 8'h40 && (o[2:0] == 3'd4 || o[2:0] == 3'd5))
                begin
                        f.seq_addr = SEQ_ADDR_W'(16 * int'(o[5:3]) + 2 * int'(KIND_IR)
                                                 + int'(o[0]));
                        f.need_imm = 1'b1;
                        f.imm_size = o[0];
                end
                else if (o >= 8'h80 && o <= 8'h83)
                begin
                        kind = (md == 2'd3) ? KIND_IR : KIND_IM;
                        f.seq_addr = SEQ_ADDR_W'(16 * int'(rg) + 2 * int'(kind) + int'(o[0]));
                        f.need_modrm = 1'b1;
                        f.need_imm = 1'b1;
                        f.imm_size = (o == 8'h81);
                        f.dst = {1'b0, rm};
                end
                else if (o >= 8'h88 && o <= 8'h8b)
                begin
                        f.need_modrm = 1'b1;
                        if (md == 2'd3)
                        begin
                                f.seq_addr = SEQ_MOVRR + SEQ_ADDR_W'(o[0]);
                                f.dst = o[1] ? {1'b0, rg} : {1'b0, rm};
                                f.src = o[1] ? {1'b0, rm} : {1'b0, rg};
                        end
                        else if (o[1])
                        begin
                                f.seq_addr = SEQ_MOVMR + SEQ_ADDR_W'(o[0]);
                                f.dst = {1'b0, rg};
                        end
                        else
                        begin
                                f.seq_addr = SEQ_MOVRM + SEQ_ADDR_W'(o[0]);
                                f.src = {1'b0, rg};
                        end
                end
                else if (o >= 8'h40 && o <= 8'h4f)
                begin
                        f.seq_addr = o[3] ? SEQ_DECRW : SEQ_INCRW;
                        f.src = {1'b0, o[2:0]};
                end
                else if (o >= 8'h50 && o <= 8'h57)
                begin
                        f.seq_addr = SEQ_PUSHR;
                        f.src = {1'b0, o[2:0]};
                end
                else if (o >= 8'h58 && o <= 8'h5f)
                begin
                        f.seq_addr = SEQ_POPR;
                        f.dst = {1'b0, o[2:0]};
                end
                else if (o >= 8'h70 && o <= 8'h7f)
                begin
                        f.seq_addr = SEQ_JCC;
                        f.need_imm = 1'b1;
                        f.src = o[3:0];
                end
                if (f.need_modrm)
                begin
                        f.need_off = direct || md == 2'd1 || md == 2'd2;
                        f.off_size = direct || md == 2'd2;
                end
                return f;
        endfunction

        task automatic send_item(input string test, input logic [7:0] o, input logic [7:0] m,
                                 input logic [2:0] s);
                while (sent_cnt - ret_cnt >= QUEUE_DEPTH)       // out of upstream credit
                        next_cycle();
                in_valid = 1'b1;
                op = o;
                modrm = m;
                sovr_pr = s;
                exp_q.push_back(expect_fields(o, m, s));
                name_q.push_back(test);
                sent_cnt++;
                next_cycle();
                in_valid = 1'b0;
        endtask

        task automatic compare_output(input string t, input fields_t e);
                check_field(t, "seq_addr", int'(e.seq_addr), int'(seq_addr));
                check_field(t, "need_modrm", int'(e.need_modrm), int'(need_modrm));
                check_field(t, "need_off", int'(e.need_off), int'(need_off));
                check_field(t, "off_size", int'(e.off_size), int'(off_size));
                check_field(t, "need_imm", int'(e.need_imm), int'(need_imm));
                check_field(t, "imm_size", int'(e.imm_size), int'(imm_size));
                check_field(t, "src", int'(e.src), int'(src));
                check_field(t, "dst", int'(e.dst), int'(dst));
                check_field(t, "base", int'(e.base), int'(base));
                check_field(t, "index", int'(e.index), int'(index));
                check_field(t, "seg", int'(e.seg), int'(seg));
        endtask

        // outputs are sampled mid-cycle
        always @(negedge clk)
        begin
                if (quiet_check)
                        assert (!out_valid && !in_credit)
                        else stop_run("out_valid or in_credit high during or just after reset");
                assert (in_credit == out_valid)
                else stop_run("in_credit does not follow out_valid");
                if (out_valid)
                begin
                        assert (owed < OUT_CREDITS)
                        else stop_run("out_valid while the decoder holds no downstream credit");
                        assert (exp_q.size() != 0)
                        else stop_run("out_valid with no item outstanding");
                        exp_f = exp_q.pop_front();
                        exp_name = name_q.pop_front();
                        compare_output(exp_name, exp_f);
                        owed++;
                end
                if (out_credit)
                        owed--;
                if (in_credit)
                        ret_cnt++;
        end

        // downstream credit return
        always @(posedge clk)
        begin
                #1;
                stretch_cnt = stretch_cnt + 5'd1;
                if (credit_mode == 0)
                        credit_pct = 0;
                else if (credit_mode == 1)
                        credit_pct = 100;
                else if (stretch_cnt == 5'd0)
                        credit_pct = 25 * int'($urandom_range(0, 4));     // 0 gives a dry stretch
                out_credit = (owed > 0) && (int'($urandom_range(0, 99)) < credit_pct);
        end

        always @(posedge clk)
        begin
                cycle_cnt++;
                if (cycle_cnt > TIMEOUT_CYCLES)
                        stop_run($sformatf("timeout after %0d cycles with %0d items outstanding",
                                           cycle_cnt, exp_q.size()));
        end

        initial
        begin
                void'($urandom(32'h4b6b));
                rst_n = 1'b0;
                in_valid = 1'b0;
                op = 8'h00;
                modrm = 8'h00;
                sovr_pr = 3'b000;
                quiet_check = 1'b1;
                repeat (16) @(posedge clk);
                #1 rst_n = 1'b1;
                repeat (3) next_cycle();
                quiet_check = 1'b0;

                credit_mode = 2;
                for (int i = 0; i < 256; i++)           // register forms
                        send_item("opcode_sweep_reg", 8'(i), {2'b11, 6'($urandom)},
                                  3'($urandom));
                for (int i = 0; i < 256; i++)
                        send_item("opcode_sweep_mem", 8'(i), 8'($urandom), 3'($urandom));
                for (int i = 0; i < 512; i++)           // every modrm, with and without override
                        send_item("ea_sweep", 8'h8b, 8'(i), {i[8], 2'($urandom)});

                credit_mode = 1;
                while (exp_q.size() != 0 || owed != 0)
                        next_cycle();
                credit_mode = 0;
                for (int i = 0; i < QUEUE_DEPTH + OUT_CREDITS; i++)
                        send_item("queue_fill", 8'($urandom), 8'($urandom), 3'($urandom));
                repeat (12) next_cycle();
                assert (exp_q.size() == QUEUE_DEPTH && owed == OUT_CREDITS &&
                        sent_cnt - ret_cnt == QUEUE_DEPTH)
                else stop_run("queue did not hold a full load without downstream credits");

                credit_mode = 2;
                for (int i = 0; i < RANDOM_ITEMS; i++)
                begin
                        repeat ($urandom_range(0, 2)) next_cycle();
                        send_item("random_mix", 8'($urandom), 8'($urandom), 3'($urandom));
                end
                credit_mode = 1;
                while (exp_q.size() != 0)
                        next_cycle();
                repeat (4) next_cycle();
                $display("all tests passed");
                $finish;
        end

endmodule

/* sources.f */
verilog/deco_pkg.sv
verilog/memory_regs.sv
verilog/modrm_stage.sv
verilog/opcode_table.sv
verilog/deco_queue.sv
verilog/opcode_deco.sv
verif/opcode_deco_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
TOP       := opcode_deco_tb
FILELIST  := sources.f
OBJDIR    := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
